//--- Makefile
# Verilator build and run for the cached memory system

VERILATOR ?= verilator
TOP       ?= memSystemTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bankedMem.sv
////////////////////////////////////////////////////////////
// Four-bank interleaved memory
// Banks are selected by address bits 2 to 1. Each bank stays
// busy for a while after an access, and read data comes out
// after a fixed latency
////////////////////////////////////////////////////////////
module bankedMem (
    input  logic                clk,
    input  logic                reset,
    input  memSysPkg::memReqT   mReq,
    output memSysPkg::bankMaskT busy,
    output memSysPkg::wordT     memData
);
    import memSysPkg::*;

    typedef logic [$clog2(bankBusyCycles + 1)-1:0] busyCntT;
    typedef logic [$clog2(bankDepth)-1:0]          rowT;

    wordT    bankArray [numBanks][bankDepth];
    busyCntT busyCnt   [numBanks];
    wordT    rdWord;                    // Word captured at the strobe edge
    wordT    rdPipe    [memReadLatency];

    wordSelT bankSel;
    rowT     row;
    logic    accept;

    assign bankSel = mReq.addr[2:1];
    assign row     = mReq.addr[15:3];
    assign accept  = (mReq.rd || mReq.wr) && !busy[bankSel];

    // Per-bank recovery counters
    for (genvar b = 0; b < numBanks; b++) begin : gBank
        always_ff @(posedge clk) begin
            if (reset) begin
                busyCnt[b] <= '0;
            end else if (accept && (bankSel == wordSelT'(b))) begin
                busyCnt[b] <= busyCntT'(bankBusyCycles);
            end else if (busyCnt[b] != '0) begin
                busyCnt[b] <= busyCnt[b] - 1'b1;
            end
        end

        assign busy[b] = (busyCnt[b] != '0);
    end

    always_ff @(posedge clk) begin
        if (accept && mReq.wr) begin
            bankArray[bankSel][row] <= mReq.wrData;
        end
        if (accept && mReq.rd) begin
            rdWord <= bankArray[bankSel][row];
        end
        rdPipe[0] <= rdWord;
        for (int i = 1; i < memReadLatency; i++) begin
            rdPipe[i] <= rdPipe[i-1];  // Latency shift
        end
    end

    assign memData = rdPipe[memReadLatency-1];

    // Controller has to wait out the recovery of a bank
    strobeNotBusy: assert property (
        @(posedge clk) disable iff (reset)
        (mReq.rd || mReq.wr) |-> !busy[bankSel]
    );

    rdWrExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(mReq.rd && mReq.wr)
    );

endmodule

//--- cacheArray.sv
////////////////////////////////////////////////////////////
// Direct-mapped cache array
// Tag, valid and four-word data storage per line with a
// combinational lookup and a synchronous write port
////////////////////////////////////////////////////////////
module cacheArray (
    input  logic                clk,
    input  logic                reset,
    input  memSysPkg::cacheReqT cReq,
    output memSysPkg::cacheRspT cRsp
);
    import memSysPkg::*;

    tagT                   tagMem  [cacheLines];
    wordT                  dataMem [cacheLines][numBanks];
    logic [cacheLines-1:0] validBits;

    logic tagMatch;
    logic hitWrite;
    logic fillWrite;

    // Lookup path
    assign tagMatch = validBits[cReq.index] && (tagMem[cReq.index] == cReq.tag);

    // Compare write lands only on a hit, fill write always lands
    assign hitWrite  = cReq.write && cReq.comp && tagMatch;
    assign fillWrite = cReq.write && cReq.validIn;

    always_comb begin
        cRsp.hit    = tagMatch;
        cRsp.rdData = dataMem[cReq.index][cReq.wordSel];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;  // Every line starts invalid
        end else if (fillWrite) begin
            validBits[cReq.index] <= 1'b1;
        end
    end

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (fillWrite) begin
            tagMem[cReq.index] <= cReq.tag;
        end
        if (hitWrite || fillWrite) begin
            dataMem[cReq.index][cReq.wordSel] <= cReq.wrData;
        end
    end

endmodule

//--- cacheController.sv
////////////////////////////////////////////////////////////
// Cache controller FSM
// Sequences tag compare, write-through, line fill and the
// done, stall, hit and error outputs to the requester
////////////////////////////////////////////////////////////
module cacheController (
    input  logic                clk,
    input  logic                reset,
    input  memSysPkg::addrT     addr,
    input  memSysPkg::wordT     dataIn,
    input  logic                rd,
    input  logic                wr,
    input  memSysPkg::cacheRspT cRsp,
    input  memSysPkg::bankMaskT busy,
    input  memSysPkg::wordT     memData,
    output memSysPkg::cacheReqT cReq,
    output memSysPkg::memReqT   mReq,
    output logic                done,
    output logic                stall,
    output logic                cacheHit,
    output logic                err,
    output memSysPkg::wordT     dataOut
);
    import memSysPkg::*;

    ctrlStateT               state;
    ctrlStateT               stateNext;
    wordSelT                 issueCnt;  // Next bank to strobe in a fill
    wordSelT                 retCnt;    // Next word expected back
    logic [memReadLatency:0] retPipe;
    logic                    missed;    // First compare of this request missed

    logic newReq;
    logic badReq;
    logic bankFree;
    logic issueNow;
    logic retValid;

    assign newReq   = (rd || wr) && (state == idle);
    assign badReq   = (rd && wr) || addr[0];
    assign bankFree = !busy[addr[2:1]];
    assign issueNow = (state == fillIssue) && !busy[issueCnt];
    assign retValid = retPipe[memReadLatency];  // Tracks the memory read latency

    assign stall = (state != idle);

    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (newReq && !badReq) begin
                    stateNext = compareTag;
                end
            end
            compareTag: begin
                if (wr) begin
                    stateNext = writeMem;
                end else if (cRsp.hit) begin
                    stateNext = finish;
                end else begin
                    stateNext = fillIssue;
                end
            end
            writeMem: begin
                if (bankFree) begin
                    stateNext = finish;
                end
            end
            fillIssue: begin
                if (issueNow && (issueCnt == wordSelT'(numBanks - 1))) begin
                    stateNext = fillDrain;
                end
            end
            fillDrain: begin
                if (retValid && (retCnt == wordSelT'(numBanks - 1))) begin
                    stateNext = compareTag;  // Recheck, now a hit
                end
            end
            default: stateNext = idle;
        endcase
    end

    // Cache port
    always_comb begin
        cReq.index   = addr[10:3];
        cReq.tag     = addr[15:11];
        cReq.wordSel = addr[2:1];
        cReq.wrData  = dataIn;
        cReq.write   = 1'b0;
        cReq.comp    = 1'b0;
        cReq.validIn = 1'b0;
        if (state == compareTag) begin
            cReq.comp  = 1'b1;
            cReq.write = wr;
        end else if ((state == fillIssue) || (state == fillDrain)) begin
            cReq.wordSel = retCnt;
            cReq.wrData  = memData;
            cReq.write   = retValid;
            cReq.validIn = retValid;
        end
    end

    // Memory port
    always_comb begin
        mReq.addr   = addr;
        mReq.wrData = dataIn;
        mReq.rd     = 1'b0;
        mReq.wr     = (state == writeMem) && bankFree;
        if (issueNow) begin
            mReq.addr = {addr[15:3], issueCnt, 1'b0};
            mReq.rd   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            issueCnt <= '0;
            retCnt   <= '0;
            retPipe  <= '0;
            missed   <= 1'b0;
            done     <= 1'b0;
            cacheHit <= 1'b0;
            err      <= 1'b0;
        end else begin
            state   <= stateNext;
            done    <= (stateNext == finish);
            err     <= newReq && badReq;
            retPipe <= {retPipe[memReadLatency-1:0], issueNow};
            if (issueNow) begin
                issueCnt <= issueCnt + 1'b1;
            end
            if (retValid) begin
                retCnt <= retCnt + 1'b1;
            end
            if (state == idle) begin
                missed <= 1'b0;
            end else if ((state == compareTag) && !cRsp.hit) begin
                missed <= 1'b1;
            end
            if (stateNext == finish) begin
                cacheHit <= !missed;  // Only the first compare counts
            end else begin
                cacheHit <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == compareTag) && cRsp.hit && !wr) begin
            dataOut <= cRsp.rdData;
        end
    end

    // A done only closes a request that the requester still holds
    doneInFinish: assert property (
        @(posedge clk) disable iff (reset)
        done |-> $past(rd || wr)
    );

endmodule

//--- list.f
memSysPkg.sv
cacheArray.sv
bankedMem.sv
cacheController.sv
memSystem.sv
memSystemChecker.sv
memSystemTb.sv

//--- memSysPkg.sv
////////////////////////////////////////////////////////////
// Memory system package
// Address fields, request and response structs, controller
// states and timing constants for the cache controller,
// the cache array and the banked memory
////////////////////////////////////////////////////////////
package memSysPkg;

    localparam int numBanks       = 4;
    localparam int cacheLines     = 256;
    localparam int bankDepth      = 8192;  // Words per bank
    localparam int bankBusyCycles = 4;     // Recovery after any access
    localparam int memReadLatency = 2;

    typedef logic [15:0] addrT;     // Byte address
    typedef logic [15:0] wordT;
    typedef logic [4:0]  tagT;      // addr[15:11]
    typedef logic [7:0]  indexT;    // addr[10:3]
    typedef logic [1:0]  wordSelT;  // addr[2:1], also the bank
    typedef logic [3:0]  bankMaskT;

    typedef enum logic [2:0] {
        idle,
        compareTag,
        writeMem,
        fillIssue,
        fillDrain,
        finish
    } ctrlStateT;

    // Strobes to the banked memory
    typedef struct packed {
        addrT addr;
        wordT wrData;
        logic rd;
        logic wr;
    } memReqT;

    typedef struct packed {
        indexT   index;
        tagT     tag;
        wordSelT wordSel;
        wordT    wrData;
        logic    write;
        logic    comp;     // Store only on a tag hit
        logic    validIn;  // Line fill, store and set tag
    } cacheReqT;

    typedef struct packed {
        logic hit;  // Valid and tag match
        wordT rdData;
    } cacheRspT;

endpackage

//--- memSystem.sv
////////////////////////////////////////////////////////////
// Cached memory system top
// Controller in front of a direct-mapped cache and a
// four-bank interleaved memory
////////////////////////////////////////////////////////////
module memSystem (
    input  logic            clk,
    input  logic            reset,
    input  memSysPkg::addrT addr,
    input  memSysPkg::wordT dataIn,
    input  logic            rd,
    input  logic            wr,
    output memSysPkg::wordT dataOut,
    output logic            done,
    output logic            stall,
    output logic            cacheHit,
    output logic            err
);
    import memSysPkg::*;

    cacheReqT cReq;
    cacheRspT cRsp;
    memReqT   mReq;
    bankMaskT busy;
    wordT     memData;

    cacheController ctrl0 (
        .clk      (clk),
        .reset    (reset),
        .addr     (addr),
        .dataIn   (dataIn),
        .rd       (rd),
        .wr       (wr),
        .cRsp     (cRsp),
        .busy     (busy),
        .memData  (memData),
        .cReq     (cReq),
        .mReq     (mReq),
        .done     (done),
        .stall    (stall),
        .cacheHit (cacheHit),
        .err      (err),
        .dataOut  (dataOut)
    );

    cacheArray cache0 (
        .clk   (clk),
        .reset (reset),
        .cReq  (cReq),
        .cRsp  (cRsp)
    );

    bankedMem mem0 (
        .clk     (clk),
        .reset   (reset),
        .mReq    (mReq),
        .busy    (busy),
        .memData (memData)
    );

endmodule

//--- memSystemChecker.sv
////////////////////////////////////////////////////////////
// Response checker for the cached memory system
// Keeps a shadow memory and a tag/valid model, compares
// every completed request and prints one line per test
////////////////////////////////////////////////////////////
module memSystemChecker (
    input  logic            clk,
    input  logic            reset,
    input  memSysPkg::addrT addr,
    input  memSysPkg::wordT dataIn,
    input  logic            rd,
    input  logic            wr,
    input  memSysPkg::wordT dataOut,
    input  logic            done,
    input  logic            stall,
    input  logic            cacheHit,
    input  logic            err,
    input  logic            fileValid,  // Expected values from the test file apply
    input  memSysPkg::wordT fileData,
    input  logic            fileHit,
    input  logic            fileErr,
    output int              testCount,
    output int              failCount
);
    import memSysPkg::*;

    wordT shadowMem  [32768];
    logic known      [32768];  // Word was written since reset
    tagT  tagModel   [cacheLines];
    logic validModel [cacheLines];

    logic busyReq;
    logic badSeen;   // Rejected request waiting for its err pulse
    logic reqRd;
    logic expHit;
    logic useFile;
    logic fHit;
    logic fErr;
    logic testOk;
    addrT reqAddr;
    wordT reqData;
    wordT fData;
    int   age;

    task automatic mismatch(input string msg);
        $display("Mismatch at time %0t: test %0d %s", $time, testCount + 1, msg);
        testOk = 1'b0;
    endtask

    task automatic closeTest();
        testCount++;
        if (!testOk) begin
            failCount++;
        end
        $display("test %0d %s addr %h %s", testCount, reqRd ? "rd" : "wr", reqAddr,
                 testOk ? "ok" : "FAILED");
    endtask

    // Sample a request exactly where the DUT takes it
    task automatic startReq();
        reqAddr = addr;
        reqData = dataIn;
        reqRd   = rd;
        age     = 0;
        testOk  = 1'b1;
        useFile = fileValid;
        fData   = fileData;
        fHit    = fileHit;
        fErr    = fileErr;
        if ((rd && wr) || addr[0]) begin
            badSeen = 1'b1;
        end else begin
            busyReq = 1'b1;
            expHit  = validModel[addr[10:3]] && (tagModel[addr[10:3]] == addr[15:11]);
        end
    endtask

    task automatic finishReq();
        busyReq = 1'b0;
        if (cacheHit !== expHit) begin
            mismatch($sformatf("cacheHit %b expected %b", cacheHit, expHit));
        end
        if (useFile && ((cacheHit !== fHit) || fErr)) begin
            mismatch($sformatf("cacheHit %b err 0, file expects %b and %b", cacheHit, fHit, fErr));
        end
        if (reqRd) begin
            if (expHit && (age != 2)) begin
                mismatch($sformatf("read hit done after %0d cycles", age));
            end
            if (known[reqAddr[15:1]] && (dataOut !== shadowMem[reqAddr[15:1]])) begin
                mismatch($sformatf("dataOut %h expected %h", dataOut, shadowMem[reqAddr[15:1]]));
            end
            if (useFile && (dataOut !== fData)) begin
                mismatch($sformatf("dataOut %h file expects %h", dataOut, fData));
            end
            validModel[reqAddr[10:3]] = 1'b1;  // Read miss allocates
            tagModel[reqAddr[10:3]]   = reqAddr[15:11];
        end else begin
            shadowMem[reqAddr[15:1]] = reqData;
            known[reqAddr[15:1]]     = 1'b1;
        end
        closeTest();
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cacheLines; i++) begin
                validModel[i] = 1'b0;
            end
            for (int i = 0; i < 32768; i++) begin
                known[i] = 1'b0;
            end
            busyReq   = 1'b0;
            badSeen   = 1'b0;
            testCount = 0;
            failCount = 0;
        end else begin
            if (badSeen) begin
                if (!err || done || stall) begin
                    $display("Rejected request at time %0t gave no clean err pulse", $time);
                    testOk = 1'b0;
                end
                if (useFile && !fErr) begin
                    mismatch("err raised but the file expects none");
                end
                badSeen = 1'b0;
                closeTest();
            end else if (busyReq) begin
                age++;
                if (!stall || err) begin
                    $display("Stall low or err high while test %0d was in progress at time %0t",
                             testCount + 1, $time);
                    testOk = 1'b0;
                end
                if (done) begin
                    finishReq();
                end
            end else if (done || err || stall) begin
                $display("Done, err or stall seen with no request at time %0t", $time);
                failCount++;
            end
            if (!busyReq && !badSeen && !stall && (rd || wr)) begin
                startReq();
            end
        end
    end

endmodule

//--- memSystemInput.txt
// op addr wrData expData expHit expErr, all hex, one test per line
// op 1 read, 2 write, 3 read and write together, 0 ends the list
2 0100 1111 0000 0 0
2 0102 2222 0000 0 0
2 0104 3333 0000 0 0
2 0106 4444 0000 0 0
1 0102 0000 2222 0 0
1 0106 0000 4444 1 0
1 0100 0000 1111 1 0
2 0102 abcd 0000 1 0
1 0102 0000 abcd 1 0
2 0902 5555 0000 0 0
1 0102 0000 abcd 1 0
1 0902 0000 5555 0 0
1 0102 0000 abcd 0 0
1 0104 0000 3333 1 0
1 0902 0000 5555 0 0
1 0902 0000 5555 1 0
2 2000 7777 0000 0 0
1 2000 0000 7777 0 0
1 2000 0000 7777 1 0
3 0100 0000 0000 0 1
1 0101 0000 0000 0 1
2 0203 9999 0000 0 1
2 0300 a1a1 0000 0 0
2 0308 b2b2 0000 0 0
1 0308 0000 b2b2 0 0
1 0300 0000 a1a1 0 0
1 0308 0000 b2b2 1 0
0 0000 0000 0000 0 0

//--- memSystemTb.sv
////////////////////////////////////////////////////////////
// Testbench for the cached memory system
// Directed requests from a file, then random traffic over
// a small address window, checked by memSystemChecker
////////////////////////////////////////////////////////////
module memSystemTb;
    import memSysPkg::*;

    localparam int maxTests  = 64;
    localparam int waitLimit = 100;  // Cycles per request

    logic   clk;
    logic   reset;
    logic   rd;
    logic   wr;
    logic   done;
    logic   stall;
    logic   cacheHit;
    logic   err;
    addrT   addr;
    wordT   dataIn;
    wordT   dataOut;
    logic   fileValid;
    logic   fileHit;
    logic   fileErr;
    wordT   fileData;
    int     testCount;
    int     failCount;
    wordT   testVec [6*maxTests];  // op addr wrData expData expHit expErr
    integer seed;
    logic   timedOut;

    memSystem dut0 (
        .clk      (clk),
        .reset    (reset),
        .addr     (addr),
        .dataIn   (dataIn),
        .rd       (rd),
        .wr       (wr),
        .dataOut  (dataOut),
        .done     (done),
        .stall    (stall),
        .cacheHit (cacheHit),
        .err      (err)
    );

    memSystemChecker chk0 (
        .clk       (clk),
        .reset     (reset),
        .addr      (addr),
        .dataIn    (dataIn),
        .rd        (rd),
        .wr        (wr),
        .dataOut   (dataOut),
        .done      (done),
        .stall     (stall),
        .cacheHit  (cacheHit),
        .err       (err),
        .fileValid (fileValid),
        .fileData  (fileData),
        .fileHit   (fileHit),
        .fileErr   (fileErr),
        .testCount (testCount),
        .failCount (failCount)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Called on a falling edge, holds the request until done or err
    task automatic runRequest(input logic doRd, input logic doWr, input addrT a, input wordT d);
        int n;
        rd     = doRd;
        wr     = doWr;
        addr   = a;
        dataIn = d;
        n      = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && !err && (n < waitLimit));
        if (!done && !err) begin
            $display("Timeout: no done or err within %0d cycles for address %h", waitLimit, a);
            timedOut = 1'b1;
        end
        rd        = 1'b0;
        wr        = 1'b0;
        fileValid = 1'b0;
    endtask

    initial begin
        int   t;
        logic [31:0] rnd;
        reset     = 1'b1;
        rd        = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        dataIn    = '0;
        fileValid = 1'b0;
        fileData  = '0;
        fileHit   = 1'b0;
        fileErr   = 1'b0;
        timedOut  = 1'b0;
        seed      = 62706;
        for (int i = 0; i < 6*maxTests; i++) begin
            testVec[i] = '0;  // Op 0 ends the list
        end
        $readmemh("memSystemInput.txt", testVec);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        t = 0;
        while ((t < maxTests) && (testVec[6*t] != '0) && !timedOut) begin
            fileValid = 1'b1;
            fileData  = testVec[6*t+3];
            fileHit   = testVec[6*t+4][0];
            fileErr   = testVec[6*t+5][0];
            runRequest(testVec[6*t][0], testVec[6*t][1], testVec[6*t+1], testVec[6*t+2]);
            t++;
        end

        // 64 even addresses, two tags over eight lines
        for (int i = 0; (i < 40) && !timedOut; i++) begin
            rnd = $random(seed);
            runRequest(!rnd[8], rnd[8], {4'b0, rnd[5], 5'b0, rnd[4:0], 1'b0}, rnd[31:16]);
        end

        repeat (2) @(negedge clk);
        $display("Tests run: %0d, failed: %0d, timeouts: %0d", testCount, failCount,
                 timedOut ? 1 : 0);
        if ((failCount == 0) && !timedOut) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
